//--- rtl/dual_issue_defs.svh
`ifndef DUAL_ISSUE_DEFS_SVH
`define DUAL_ISSUE_DEFS_SVH

// architectural register file shape
`define DI_NREG 32
`define DI_RW   5
`define DI_XLEN 32

// major opcodes, instruction bits [31:26]
// register-register forms
`define DI_OP_ADD  6'h01
`define DI_OP_SUB  6'h02
`define DI_OP_AND  6'h03
`define DI_OP_OR   6'h04
`define DI_OP_XOR  6'h05
`define DI_OP_SLT  6'h06

// 12-bit immediate forms
`define DI_OP_ADDI 6'h0a
`define DI_OP_ANDI 6'h0d
`define DI_OP_ORI  6'h0e

`endif

//--- rtl/dual_issue_pkg.sv
`include "dual_issue_defs.svh"

package dual_issue_pkg;

    // register-register view of an instruction word
    typedef struct packed {
        logic [5:0]         opcode;
        logic [10:0]        unused;
        logic [`DI_RW-1:0]  rk;
        logic [`DI_RW-1:0]  rj;
        logic [`DI_RW-1:0]  rd;
    } r_fmt_t;

    // immediate view, imm12 sits where rk and part of the spare bits were
    typedef struct packed {
        logic [5:0]         opcode;
        logic [3:0]         unused;
        logic [11:0]        imm12;
        logic [`DI_RW-1:0]  rj;
        logic [`DI_RW-1:0]  rd;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5,
        ALU_SLT = 3'd6
    } alu_op_e;

    typedef struct packed {
        logic                valid;
        alu_op_e             op;
        logic [`DI_RW-1:0]   rd;
        logic [`DI_RW-1:0]   rj;
        logic [`DI_RW-1:0]   rk;
        logic                use_imm;
        logic [`DI_XLEN-1:0] imm;
        logic                writes;
    } uop_t;

    // inst0 is older in program order
    typedef struct packed {
        inst_u inst0;
        inst_u inst1;
    } pair_t;

    typedef struct packed {
        logic                valid;
        alu_op_e             op;
        logic [`DI_RW-1:0]   rd;
        logic                writes;
        logic [`DI_XLEN-1:0] src_a;
        logic [`DI_XLEN-1:0] src_b;
    } exe_slot_t;

    typedef struct packed {
        logic                valid;
        logic [`DI_RW-1:0]   rd;
        logic [`DI_XLEN-1:0] value;
    } wb_t;

endpackage

//--- rtl/inst_decode.sv
`timescale 1ns/1ns
`include "dual_issue_defs.svh"

module inst_decode (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  pair_req,
    input  dual_issue_pkg::pair_t pair,
    output logic                  pair_ack,
    input  logic                  dec_take,
    output logic                  dec_valid,
    output dual_issue_pkg::uop_t  uop0,
    output dual_issue_pkg::uop_t  uop1
);

    dual_issue_pkg::pair_t pair_q;
    logic                  load;

    // one word into a micro-op, the opcode picks which union view to trust
    function automatic dual_issue_pkg::uop_t decode_word(
        input dual_issue_pkg::inst_u w,
        input logic                  v
    );
        dual_issue_pkg::uop_t u;
        u       = '0;
        u.valid = v;
        u.op    = dual_issue_pkg::ALU_NOP;
        case (w.r_fmt.opcode)
            `DI_OP_ADD:  u.op = dual_issue_pkg::ALU_ADD;
            `DI_OP_SUB:  u.op = dual_issue_pkg::ALU_SUB;
            `DI_OP_AND:  u.op = dual_issue_pkg::ALU_AND;
            `DI_OP_OR:   u.op = dual_issue_pkg::ALU_OR;
            `DI_OP_XOR:  u.op = dual_issue_pkg::ALU_XOR;
            `DI_OP_SLT:  u.op = dual_issue_pkg::ALU_SLT;
            `DI_OP_ADDI: begin
                u.op      = dual_issue_pkg::ALU_ADD;
                u.use_imm = 1'b1;
            end
            `DI_OP_ANDI: begin
                u.op      = dual_issue_pkg::ALU_AND;
                u.use_imm = 1'b1;
            end
            `DI_OP_ORI: begin
                u.op      = dual_issue_pkg::ALU_OR;
                u.use_imm = 1'b1;
            end
            default: u.op = dual_issue_pkg::ALU_NOP;
        endcase
        // unknown opcodes keep all register fields at zero and read nothing
        if (u.op != dual_issue_pkg::ALU_NOP) begin
            if (u.use_imm) begin
                u.rd  = w.i_fmt.rd;
                u.rj  = w.i_fmt.rj;
                u.imm = {{(`DI_XLEN-12){w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
            end else begin
                u.rd = w.r_fmt.rd;
                u.rj = w.r_fmt.rj;
                u.rk = w.r_fmt.rk;
            end
        end
        u.writes = (u.rd != '0) && (u.op != dual_issue_pkg::ALU_NOP);
        return u;
    endfunction

    // decode register free when empty or being drained this cycle
    assign load = pair_req && !pair_ack && (!dec_valid || dec_take);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pair_ack  <= 1'b0;
            dec_valid <= 1'b0;
            pair_q    <= '0;
        end else begin
            // ack goes up with the load, down once req is seen low
            if (load) begin
                pair_ack <= 1'b1;
            end else if (!pair_req) begin
                pair_ack <= 1'b0;
            end
            if (load) begin
                dec_valid <= 1'b1;
                pair_q    <= pair;
            end else if (dec_take) begin
                dec_valid <= 1'b0;
            end
        end
    end

    assign uop0 = decode_word(pair_q.inst0, dec_valid);
    assign uop1 = decode_word(pair_q.inst1, dec_valid);

endmodule

//--- rtl/issue_split.sv
`timescale 1ns/1ns
`include "dual_issue_defs.svh"

module issue_split (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      dec_valid,
    input  dual_issue_pkg::uop_t      uop0,
    input  dual_issue_pkg::uop_t      uop1,
    output logic                      dec_take,
    output logic [3:0][`DI_RW-1:0]    rd_addr,
    input  logic [3:0][`DI_XLEN-1:0]  rd_data,
    input  dual_issue_pkg::wb_t       fwd_ex0,
    input  dual_issue_pkg::wb_t       fwd_ex1,
    input  dual_issue_pkg::wb_t       res0,
    input  dual_issue_pkg::wb_t       res1,
    output dual_issue_pkg::exe_slot_t exe0,
    output dual_issue_pkg::exe_slot_t exe1
);

    // set while the younger half of a split pair is still waiting
    logic                      second_q;
    logic                      dep;
    dual_issue_pkg::uop_t      lane_a;
    dual_issue_pkg::exe_slot_t slot0_d;
    dual_issue_pkg::exe_slot_t slot1_d;

    // checked oldest to youngest so the last hit wins
    function automatic logic [`DI_XLEN-1:0] fwd_pick(
        input logic [`DI_RW-1:0]   addr,
        input logic [`DI_XLEN-1:0] rf_val
    );
        logic [`DI_XLEN-1:0] v;
        v = rf_val;
        if (res0.valid && res0.rd == addr) v = res0.value;
        if (res1.valid && res1.rd == addr) v = res1.value;
        if (fwd_ex0.valid && fwd_ex0.rd == addr) v = fwd_ex0.value;
        if (fwd_ex1.valid && fwd_ex1.rd == addr) v = fwd_ex1.value;
        return v;
    endfunction

    function automatic dual_issue_pkg::exe_slot_t build_slot(
        input dual_issue_pkg::uop_t u,
        input logic                 issue,
        input logic [`DI_XLEN-1:0]  rf_a,
        input logic [`DI_XLEN-1:0]  rf_b
    );
        dual_issue_pkg::exe_slot_t s;
        s.valid  = issue;
        s.op     = u.op;
        s.rd     = u.rd;
        s.writes = u.writes;
        s.src_a  = fwd_pick(u.rj, rf_a);
        s.src_b  = u.use_imm ? u.imm : fwd_pick(u.rk, rf_b);
        return s;
    endfunction

    // inst1 reads what inst0 writes, so the pair has to split
    assign dep = uop0.writes &&
                 ((uop0.rd == uop1.rj) || (!uop1.use_imm && (uop0.rd == uop1.rk)));

    // lane 0 carries inst1 during the second half of a split
    assign lane_a   = second_q ? uop1 : uop0;
    assign dec_take = dec_valid && (second_q || !dep);

    assign rd_addr[0] = lane_a.rj;
    assign rd_addr[1] = lane_a.rk;
    assign rd_addr[2] = uop1.rj;
    assign rd_addr[3] = uop1.rk;

    always_comb begin
        slot0_d = build_slot(lane_a, lane_a.valid, rd_data[0], rd_data[1]);
        slot1_d = build_slot(uop1, uop1.valid && !second_q && !dep, rd_data[2], rd_data[3]);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            second_q <= 1'b0;
            exe0     <= '0;
            exe1     <= '0;
        end else begin
            second_q <= dec_valid && !second_q && dep;
            exe0     <= slot0_d;
            exe1     <= slot1_d;
        end
    end

endmodule

//--- rtl/alu_execute.sv
`timescale 1ns/1ns
`include "dual_issue_defs.svh"

module alu_execute (
    input  logic                      clk,
    input  logic                      rstn,
    input  dual_issue_pkg::exe_slot_t exe0,
    input  dual_issue_pkg::exe_slot_t exe1,
    output dual_issue_pkg::wb_t       fwd_ex0,
    output dual_issue_pkg::wb_t       fwd_ex1,
    output dual_issue_pkg::wb_t       res0,
    output dual_issue_pkg::wb_t       res1
);

    function automatic logic [`DI_XLEN-1:0] alu(
        input dual_issue_pkg::alu_op_e op,
        input logic [`DI_XLEN-1:0]     a,
        input logic [`DI_XLEN-1:0]     b
    );
        logic [`DI_XLEN-1:0] r;
        case (op)
            dual_issue_pkg::ALU_ADD: r = a + b;
            dual_issue_pkg::ALU_SUB: r = a - b;
            dual_issue_pkg::ALU_AND: r = a & b;
            dual_issue_pkg::ALU_OR:  r = a | b;
            dual_issue_pkg::ALU_XOR: r = a ^ b;
            // signed compare, result is 0 or 1
            dual_issue_pkg::ALU_SLT: r = {{(`DI_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default:                 r = '0;
        endcase
        return r;
    endfunction

    // same lane logic on both slots
    function automatic dual_issue_pkg::wb_t lane(input dual_issue_pkg::exe_slot_t s);
        dual_issue_pkg::wb_t w;
        w.valid = s.valid && s.writes;
        w.rd    = s.rd;
        w.value = alu(s.op, s.src_a, s.src_b);
        return w;
    endfunction

    always_comb begin
        fwd_ex0 = lane(exe0);
        fwd_ex1 = lane(exe1);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res0 <= '0;
            res1 <= '0;
        end else begin
            res0 <= fwd_ex0;
            res1 <= fwd_ex1;
        end
    end

endmodule

//--- rtl/result_regfile.sv
`timescale 1ns/1ns
`include "dual_issue_defs.svh"

module result_regfile (
    input  logic                     clk,
    input  logic                     rstn,
    input  dual_issue_pkg::wb_t      res0,
    input  dual_issue_pkg::wb_t      res1,
    input  logic [3:0][`DI_RW-1:0]   rd_addr,
    output logic [3:0][`DI_XLEN-1:0] rd_data,
    output dual_issue_pkg::wb_t      wb0,
    output dual_issue_pkg::wb_t      wb1
);

    // r0 is not stored
    logic [`DI_XLEN-1:0] regs [1:`DI_NREG-1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 1; i < `DI_NREG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (res0.valid && res0.rd != '0) begin
                regs[res0.rd] <= res0.value;
            end
            // port 1 is younger, written last
            if (res1.valid && res1.rd != '0) begin
                regs[res1.rd] <= res1.value;
            end
        end
    end

    // no bypass here, issue forwards from res itself
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (rd_addr[p] == '0) begin
                rd_data[p] = '0;
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

    // writes committing at the next edge
    assign wb0 = res0;
    assign wb1 = res1;

endmodule

//--- rtl/dual_issue_core.sv
`timescale 1ns/1ns
`include "dual_issue_defs.svh"

module dual_issue_core (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  pair_req,
    input  dual_issue_pkg::pair_t pair,
    output logic                  pair_ack,
    output dual_issue_pkg::wb_t   wb0,
    output dual_issue_pkg::wb_t   wb1
);

    logic                      dec_valid;
    logic                      dec_take;
    dual_issue_pkg::uop_t      uop0;
    dual_issue_pkg::uop_t      uop1;
    logic [3:0][`DI_RW-1:0]    rd_addr;
    logic [3:0][`DI_XLEN-1:0]  rd_data;
    dual_issue_pkg::exe_slot_t exe0;
    dual_issue_pkg::exe_slot_t exe1;
    dual_issue_pkg::wb_t       fwd_ex0;
    dual_issue_pkg::wb_t       fwd_ex1;
    dual_issue_pkg::wb_t       res0;
    dual_issue_pkg::wb_t       res1;

    inst_decode u_decode (
        .clk       (clk),
        .rstn      (rstn),
        .pair_req  (pair_req),
        .pair      (pair),
        .pair_ack  (pair_ack),
        .dec_take  (dec_take),
        .dec_valid (dec_valid),
        .uop0      (uop0),
        .uop1      (uop1)
    );

    issue_split u_issue (
        .clk       (clk),
        .rstn      (rstn),
        .dec_valid (dec_valid),
        .uop0      (uop0),
        .uop1      (uop1),
        .dec_take  (dec_take),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .fwd_ex0   (fwd_ex0),
        .fwd_ex1   (fwd_ex1),
        .res0      (res0),
        .res1      (res1),
        .exe0      (exe0),
        .exe1      (exe1)
    );

    alu_execute u_execute (
        .clk     (clk),
        .rstn    (rstn),
        .exe0    (exe0),
        .exe1    (exe1),
        .fwd_ex0 (fwd_ex0),
        .fwd_ex1 (fwd_ex1),
        .res0    (res0),
        .res1    (res1)
    );

    result_regfile u_regfile (
        .clk     (clk),
        .rstn    (rstn),
        .res0    (res0),
        .res1    (res1),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wb0     (wb0),
        .wb1     (wb1)
    );

endmodule

//--- tb/tb_dual_issue.sv
`timescale 1ns/1ns
`include "dual_issue_defs.svh"

module tb_dual_issue;

    localparam int WAIT_LIMIT = 40;

    logic                  clk;
    logic                  rstn;
    logic                  pair_req;
    dual_issue_pkg::pair_t pair;
    logic                  pair_ack;
    dual_issue_pkg::wb_t   wb0;
    dual_issue_pkg::wb_t   wb1;

    // model registers and expected writes in commit order
    logic [`DI_XLEN-1:0] mregs [`DI_NREG];
    dual_issue_pkg::wb_t exp_q[$];
    int                  exp_port[$];
    // cycles after the previous write, -1 when unconstrained
    int                  exp_gap[$];
    int                  cycle;
    int                  last_cycle;
    int                  errors;
    int                  checks;
    int                  tests;
    int                  err_mark;
    logic [5:0]          rr_ops [6];
    logic [5:0]          imm_ops [3];

    dual_issue_core UUT (
        .clk      (clk),
        .rstn     (rstn),
        .pair_req (pair_req),
        .pair     (pair),
        .pair_ack (pair_ack),
        .wb0      (wb0),
        .wb1      (wb1)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic dual_issue_pkg::inst_u enc_r(input logic [5:0] op,
        input logic [`DI_RW-1:0] rd, input logic [`DI_RW-1:0] rj, input logic [`DI_RW-1:0] rk);
        dual_issue_pkg::inst_u w;
        w = '0;
        w.r_fmt.opcode = op;
        w.r_fmt.rd = rd;
        w.r_fmt.rj = rj;
        w.r_fmt.rk = rk;
        return w;
    endfunction

    function automatic dual_issue_pkg::inst_u enc_i(input logic [5:0] op,
        input logic [`DI_RW-1:0] rd, input logic [`DI_RW-1:0] rj, input logic [11:0] imm);
        dual_issue_pkg::inst_u w;
        w = '0;
        w.i_fmt.opcode = op;
        w.i_fmt.rd = rd;
        w.i_fmt.rj = rj;
        w.i_fmt.imm12 = imm;
        return w;
    endfunction

    function automatic logic [`DI_RW-1:0] rnd_reg();
        return $urandom_range(1, `DI_NREG - 1);
    endfunction

    // source registers of one word, unknown opcodes read nothing
    function automatic logic reads_reg(input dual_issue_pkg::inst_u w,
        input logic [`DI_RW-1:0] r);
        logic [5:0] op;
        op = w.r_fmt.opcode;
        if (op inside {`DI_OP_ADDI, `DI_OP_ANDI, `DI_OP_ORI}) begin
            return w.i_fmt.rj == r;
        end
        if (op inside {`DI_OP_ADD, `DI_OP_SUB, `DI_OP_AND, `DI_OP_OR, `DI_OP_XOR, `DI_OP_SLT}) begin
            return (w.r_fmt.rj == r) || (w.r_fmt.rk == r);
        end
        return 1'b0;
    endfunction

    // executes one word on the model, returns whether it writes
    function automatic logic exec_word(input dual_issue_pkg::inst_u w,
        output dual_issue_pkg::wb_t r);
        logic [`DI_XLEN-1:0] a;
        logic [`DI_XLEN-1:0] b;
        logic [`DI_XLEN-1:0] imm;
        a = mregs[w.r_fmt.rj];
        b = mregs[w.r_fmt.rk];
        imm = {{(`DI_XLEN-12){w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
        r.valid = 1'b1;
        r.rd = w.r_fmt.rd;
        r.value = '0;
        case (w.r_fmt.opcode)
            `DI_OP_ADD:  r.value = a + b;
            `DI_OP_SUB:  r.value = a - b;
            `DI_OP_AND:  r.value = a & b;
            `DI_OP_OR:   r.value = a | b;
            `DI_OP_XOR:  r.value = a ^ b;
            `DI_OP_SLT:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `DI_OP_ADDI: r.value = a + imm;
            `DI_OP_ANDI: r.value = a & imm;
            `DI_OP_ORI:  r.value = a | imm;
            default:     r.valid = 1'b0;
        endcase
        if (r.rd == '0) begin
            r.valid = 1'b0;
        end
        if (r.valid) begin
            mregs[r.rd] = r.value;
        end
        return r.valid;
    endfunction

    // a dependent pair splits, so both of its writes come out on wb0
    function automatic void model_pair(input dual_issue_pkg::pair_t p);
        dual_issue_pkg::wb_t w0;
        dual_issue_pkg::wb_t w1;
        logic                dep;
        logic                wrote0;
        dep = 1'b0;
        wrote0 = 1'b0;
        if (exec_word(p.inst0, w0)) begin
            dep = reads_reg(p.inst1, w0.rd);
            wrote0 = 1'b1;
            exp_q.push_back(w0);
            exp_port.push_back(0);
            exp_gap.push_back(-1);
        end
        if (exec_word(p.inst1, w1)) begin
            exp_q.push_back(w1);
            exp_port.push_back(dep ? 0 : 1);
            // paired writes share a cycle, split ones follow back to back
            exp_gap.push_back(!wrote0 ? -1 : (dep ? 1 : 0));
        end
    endfunction

    task automatic abort_run(input string why);
        $display("%s, time %0t", why, $time);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic check_wb(input dual_issue_pkg::wb_t got, input int port);
        dual_issue_pkg::wb_t exp;
        int                  exp_p;
        int                  exp_g;
        checks++;
        if (exp_q.size() == 0) begin
            $display("unexpected write of r%0d on wb%0d, time %0t", got.rd, port, $time);
            errors++;
        end else begin
            exp = exp_q.pop_front();
            exp_p = exp_port.pop_front();
            exp_g = exp_gap.pop_front();
            if (got.rd !== exp.rd || got.value !== exp.value || port != exp_p) begin
                $display("ERROR %0t: wb%0d wrote r%0d=%h, expected wb%0d r%0d=%h",
                         $time, port, got.rd, got.value, exp_p, exp.rd, exp.value);
                errors++;
            end
            if (exp_g >= 0 && cycle - last_cycle != exp_g) begin
                $display("write r%0d on wb%0d off by %0d cycles from its pair, time %0t",
                         got.rd, port, cycle - last_cycle - exp_g, $time);
                errors++;
            end
            last_cycle = cycle;
        end
    endtask

    task automatic send_pair(input dual_issue_pkg::inst_u i0, input dual_issue_pkg::inst_u i1);
        int n;
        if (pair_ack) begin
            $display("handshake order broken, ack high before a new request, time %0t", $time);
            errors++;
        end
        pair.inst0 = i0;
        pair.inst1 = i1;
        model_pair(pair);
        pair_req = 1'b1;
        n = 0;
        @(negedge clk);
        while (!pair_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!pair_ack) begin
            abort_run("handshake stalled, ack never rose after the request");
        end
        pair_req = 1'b0;
        n = 0;
        @(negedge clk);
        while (pair_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pair_ack) begin
            abort_run("handshake stalled, ack never fell after the request dropped");
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            abort_run($sformatf("expected writebacks never arrived in test %s", name));
        end
        // idle cycles so a stray write is caught in this test
        repeat (6) @(negedge clk);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    always @(negedge clk) begin
        cycle++;
        if (rstn) begin
            if (wb0.valid) begin
                check_wb(wb0, 0);
            end
            if (wb1.valid) begin
                check_wb(wb1, 1);
            end
        end
    end

    initial begin
        logic [`DI_RW-1:0] x;
        logic [`DI_RW-1:0] y;
        logic [`DI_RW-1:0] z;
        void'($urandom(32'hdf5));
        rr_ops = '{`DI_OP_ADD, `DI_OP_SUB, `DI_OP_AND, `DI_OP_OR, `DI_OP_XOR, `DI_OP_SLT};
        imm_ops = '{`DI_OP_ADDI, `DI_OP_ANDI, `DI_OP_ORI};
        errors = 0;
        checks = 0;
        tests = 0;
        err_mark = 0;
        cycle = 0;
        last_cycle = 0;
        for (int i = 0; i < `DI_NREG; i++) begin
            mregs[i] = '0;
        end
        rstn = 1'b0;
        pair_req = 1'b0;
        pair = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (pair_ack !== 1'b0) begin
            $display("ack is not low after reset, time %0t", $time);
            errors++;
        end

        // seed registers, then independent register-register pairs
        for (int i = 1; i < `DI_NREG - 1; i += 2) begin
            send_pair(enc_i(`DI_OP_ADDI, i, 0, $urandom), enc_i(`DI_OP_ADDI, i + 1, 0, $urandom));
        end
        repeat (20) begin
            x = rnd_reg();
            do begin
                y = rnd_reg();
                z = rnd_reg();
            end while (y == x || z == x);
            send_pair(enc_r(rr_ops[$urandom_range(0, 5)], x, rnd_reg(), rnd_reg()),
                      enc_r(rr_ops[$urandom_range(0, 5)], rnd_reg(), y, z));
        end
        finish_test("independent pairs");

        repeat (12) begin
            x = rnd_reg();
            y = rnd_reg();
            if ($urandom_range(0, 1)) begin
                send_pair(enc_r(rr_ops[$urandom_range(0, 5)], x, rnd_reg(), rnd_reg()),
                          enc_r(rr_ops[$urandom_range(0, 5)], rnd_reg(), x, y));
            end else begin
                send_pair(enc_r(rr_ops[$urandom_range(0, 5)], x, rnd_reg(), rnd_reg()),
                          enc_r(rr_ops[$urandom_range(0, 5)], rnd_reg(), y, x));
            end
        end
        finish_test("dependent pairs");

        // split pair, then a pair reading from execute and res
        repeat (12) begin
            x = rnd_reg();
            y = rnd_reg();
            send_pair(enc_r(rr_ops[$urandom_range(0, 5)], x, rnd_reg(), rnd_reg()),
                      enc_r(rr_ops[$urandom_range(0, 5)], y, x, rnd_reg()));
            send_pair(enc_r(rr_ops[$urandom_range(0, 5)], rnd_reg(), y, x),
                      enc_r(rr_ops[$urandom_range(0, 5)], rnd_reg(), x, y));
        end
        finish_test("back-to-back forwarding");

        send_pair(enc_i(`DI_OP_ADDI, 1, 0, 12'hffb), enc_i(`DI_OP_ADDI, 2, 0, 12'h003));
        send_pair(enc_r(`DI_OP_SLT, 3, 1, 2), enc_r(`DI_OP_SLT, 4, 2, 1));
        repeat (12) begin
            send_pair(enc_i(imm_ops[$urandom_range(0, 2)], rnd_reg(), rnd_reg(),
                            12'h800 | $urandom),
                      enc_r(`DI_OP_SLT, rnd_reg(), rnd_reg(), rnd_reg()));
        end
        finish_test("immediates and signed compare");

        send_pair(enc_r(`DI_OP_ADD, 0, 1, 2), enc_r(6'h3f, 7, 1, 2));
        send_pair(enc_i(`DI_OP_ORI, 0, 3, 12'h0ff), enc_r(6'h00, 9, 4, 5));
        // both lanes write r5, read back afterwards
        send_pair(enc_r(`DI_OP_ADD, 5, 1, 2), enc_r(`DI_OP_XOR, 5, 3, 4));
        send_pair(enc_r(`DI_OP_OR, 6, 5, 0), enc_i(`DI_OP_ADDI, 7, 5, 12'h000));
        finish_test("edge cases");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/dual_issue_pkg.sv
rtl/inst_decode.sv
rtl/issue_split.sv
rtl/alu_execute.sv
rtl/result_regfile.sv
rtl/dual_issue_core.sv
tb/tb_dual_issue.sv
